// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= cpu16_tb
RTL_TOP   ?= cpu16_top
FILELIST  ?= cpu16.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing
LINTFLAGS ?= --lint-only -Wall --timing
PASS_MSG  ?= All tests passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== cpu16.f ====
hdl/cpu16_pkg.sv
hdl/cpu16_decode.sv
hdl/cpu16_regfile.sv
hdl/cpu16_hazard.sv
hdl/cpu16_execute.sv
hdl/cpu16_top.sv
dv/cpu16_tb.sv

// ==== dv/cpu16_stimulus.txt ====
# kind addr value: I program word, D initial data word, E expected store in order
# all fields hex, anything after the value is ignored
I 0000 6920  # li    r1, 0x20
I 0001 6A05  # li    r2, 0x05
I 0002 4A03  # addiu r2, 3          r2 = 0x0008
I 0003 E14D  # addu  r3 = r1 + r2   r3 = 0x0028
I 0004 E353  # subu  r4 = r3 - r2   r4 = 0x0020
I 0005 6D5A  # li    r5, 0x5a
I 0006 E578  # and   r6 = r5 & r3   r6 = 0x0008
I 0007 E69E  # or    r7 = r6 | r4   r7 = 0x0028
I 0008 4F80  # addiu r7, -128       r7 = 0xffa8
I 0009 D9E0  # sw    r7 -> [r1 + 0]
I 000A D9C1  # sw    r6 -> [r1 + 1]
I 000B 996F  # lw    r3 <- [r1 + 15]
I 000C E351  # addu  r4 = r3 + r2   load-use
I 000D D982  # sw    r4 -> [r1 + 2]
I 000E 99BE  # lw    r5 <- [r1 - 2]
I 000F D9A3  # sw    r5 -> [r1 + 3] load-use on store data
I 0010 1002  # b     +2
I 0011 D924  # sw    skipped
I 0012 D925  # sw    skipped
I 0013 E48B  # subu  r2 = r4 - r4   r2 = 0
I 0014 2202  # beqz  r2, +2         taken
I 0015 D926  # sw    skipped
I 0016 D927  # sw    skipped
I 0017 2102  # beqz  r1, +2         not taken
I 0018 D968  # sw    r3 -> [r1 + 8]
I 0019 17FF  # b     -1             final loop
D 002F 1234
D 001E BEEF
E 0020 FFA8
E 0021 0008
E 0022 123C
E 0023 BEEF
E 0028 1234

// ==== dv/cpu16_tb.sv ====
`timescale 1ns/1ps

module cpu16_tb
    import cpu16_pkg::*;
();

    localparam pc_t reset_pc      = 16'h0000;
    localparam int  reset_cycles  = 5;
    localparam int  store_timeout = 60;
    localparam int  loop_timeout  = 40;
    localparam int  loop_visits   = 3;

    logic  clk_50MHz;
    logic  rst;
    pc_t   imem_addr;
    inst_t imem_data;
    word_t dmem_addr;
    word_t dmem_wdata;
    logic  dmem_we;
    logic  dmem_re;
    word_t dmem_rdata;

    inst_t imem [256];
    word_t dmem [256];
    word_t exp_addr [$];
    word_t exp_data [$];
    pc_t   loop_pc;
    int    test_errors;
    int    pass_count;
    int    fail_count;

    cpu16_top #(
        .reset_pc (reset_pc)
    ) UUT (
        .clk_50MHz  (clk_50MHz),
        .rst        (rst),
        .imem_addr  (imem_addr),
        .imem_data  (imem_data),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_we    (dmem_we),
        .dmem_re    (dmem_re),
        .dmem_rdata (dmem_rdata)
    );

    initial begin
        clk_50MHz = 1'b0;
        forever #10 clk_50MHz = ~clk_50MHz;
    end

    // memories answer once the new addresses are out
    always @(posedge clk_50MHz) begin
        #1;
        imem_data  = imem[imem_addr[7:0]];
        // read data only while the read strobe is up
        dmem_rdata = dmem_re ? dmem[dmem_addr[7:0]] : '0;
    end

    // ************************************************************
    // compare tasks
    // ************************************************************

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("error at %0t ns: %s is %b, expected %b", $time, name, got, exp);
            test_errors++;
        end
    endtask

    task automatic check_pc(input string name, input pc_t got, input pc_t exp);
        if (got !== exp) begin
            $display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            test_errors++;
        end
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            test_errors++;
        end
    endtask

    task automatic check_addr(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            test_errors++;
        end
    endtask

    task automatic finish_test(input string name);
        if (test_errors == 0) begin
            pass_count++;
            $display("%s: pass", name);
        end else begin
            fail_count++;
            $display("%s: FAIL with %0d errors", name, test_errors);
        end
        test_errors = 0;
    endtask

    // ************************************************************
    // stimulus file and store monitor
    // ************************************************************

    task automatic load_stimulus(output logic ok);
        int          fd;
        int          n;
        int          i;
        int          bad;
        string       line;
        logic [7:0]  kind;
        logic [15:0] a;
        logic [15:0] v;
        bad = 0;
        // unused bits of the nop fill carry the address
        for (i = 0; i < 256; i++) begin
            imem[i] = {op_nop, 3'b000, 8'(i)};
            dmem[i] = {8'(i), ~8'(i)};
        end
        loop_pc = '0;
        fd = $fopen("dv/cpu16_stimulus.txt", "r");
        if (fd == 0) begin
            $display("cannot open dv/cpu16_stimulus.txt");
            ok = 1'b0;
            return;
        end
        while ($fgets(line, fd) > 0) begin
            if (line.len() < 3 || line.getc(0) == "#") begin
                continue;
            end
            kind = line.getc(0);
            n = $sscanf(line.substr(1, line.len() - 1), "%h %h", a, v);
            if (n != 2) begin
                $display("malformed stimulus line: %s", line);
                bad++;
                continue;
            end
            case (kind)
                "I": begin
                    imem[a[7:0]] = v;
                    // last program word is the final self-branch
                    if (a > loop_pc) begin
                        loop_pc = a;
                    end
                end
                "D": dmem[a[7:0]] = v;
                "E": begin
                    exp_addr.push_back(a);
                    exp_data.push_back(v);
                end
                default: begin
                    $display("unknown record kind in stimulus line: %s", line);
                    bad++;
                end
            endcase
        end
        $fclose(fd);
        ok = (bad == 0) && (exp_addr.size() > 0);
    endtask

    task automatic wait_store(output word_t addr, output word_t data, output logic seen);
        int cycles;
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < store_timeout) begin
            @(negedge clk_50MHz);
            cycles++;
            if (dmem_we) begin
                seen = 1'b1;
                addr = dmem_addr;
                data = dmem_wdata;
                dmem[dmem_addr[7:0]] = dmem_wdata;
            end
        end
    endtask

    // ************************************************************
    // test sequence
    // ************************************************************

    initial begin
        word_t got_addr;
        word_t got_data;
        logic  seen;
        logic  loaded;
        int    idx;
        int    cycles;
        int    visits;
        pc_t   last_pc;
        rst         = 1'b0;
        imem_data   = '0;
        dmem_rdata  = '0;
        test_errors = 0;
        pass_count  = 0;
        fail_count  = 0;
        load_stimulus(loaded);
        if (!loaded) begin
            $display("stimulus file missing or malformed, no tests run");
            fail_count++;
        end else begin
            for (idx = 0; idx < reset_cycles; idx++) begin
                @(posedge clk_50MHz);
                #1;
                check_bit("dmem_we", dmem_we, 1'b0);
                check_bit("dmem_re", dmem_re, 1'b0);
            end
            rst = 1'b1;
            @(negedge clk_50MHz);
            check_pc("imem_addr", imem_addr, reset_pc);
            check_bit("dmem_we", dmem_we, 1'b0);
            check_bit("dmem_re", dmem_re, 1'b0);
            finish_test("reset");

            // stores must arrive in file order, skipped slots would mismatch
            idx  = 0;
            seen = 1'b1;
            while (seen && idx < exp_addr.size()) begin
                wait_store(got_addr, got_data, seen);
                if (!seen) begin
                    $display("timeout: store %0d did not arrive within %0d cycles",
                             idx, store_timeout);
                    test_errors++;
                end else begin
                    check_addr("dmem_addr", got_addr, exp_addr[idx]);
                    check_word("dmem_wdata", got_data, exp_data[idx]);
                end
                finish_test($sformatf("store %0d", idx));
                idx++;
            end

            if (seen) begin
                cycles  = 0;
                visits  = 0;
                last_pc = imem_addr;
                while (visits < loop_visits && cycles < loop_timeout) begin
                    @(negedge clk_50MHz);
                    cycles++;
                    if (dmem_we) begin
                        $display("unexpected store to %h at %0t ns", dmem_addr, $time);
                        test_errors++;
                    end
                    // count arrivals at the loop address only
                    if (imem_addr == loop_pc && last_pc != loop_pc) begin
                        visits++;
                    end
                    last_pc = imem_addr;
                end
                if (visits < loop_visits) begin
                    $display("timeout: fetch never settled into the loop at %h", loop_pc);
                    test_errors++;
                end
                finish_test("final loop");
            end
        end
        $display("summary: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== hdl/cpu16_decode.sv ====
`timescale 1ns/1ps

module cpu16_decode
    import cpu16_pkg::*;
(
    input  inst_t inst,
    output ctrl_t ctrl,
    output word_t imm
);

    opcode_e    opcode;
    logic [1:0] funct;
    reg_addr_t  rx;
    reg_addr_t  ry;
    reg_addr_t  rz;

    assign opcode = opcode_e'(inst[15:11]);
    assign funct  = inst[1:0];
    assign rx     = inst[10:8];
    assign ry     = inst[7:5];
    assign rz     = inst[4:2];

    // ************************************************************
    // control fields
    // ************************************************************

    always_comb begin
        // unknown opcodes fall through as a nop
        ctrl = '0;
        case (opcode)
            op_rtype: begin
                ctrl.reg_we  = 1'b1;
                ctrl.wb_addr = rz;
                case (funct)
                    funct_addu: ctrl.alu_op = alu_add;
                    funct_subu: ctrl.alu_op = alu_sub;
                    funct_and:  ctrl.alu_op = alu_and;
                    funct_or:   ctrl.alu_op = alu_or;
                    default:    ctrl.alu_op = alu_add;
                endcase
            end
            op_addiu: begin
                ctrl.use_imm = 1'b1;
                ctrl.reg_we  = 1'b1;
                ctrl.wb_addr = rx;
            end
            op_li: begin
                ctrl.alu_op  = alu_pass_b;
                ctrl.use_imm = 1'b1;
                ctrl.reg_we  = 1'b1;
                ctrl.wb_addr = rx;
            end
            op_lw: begin
                // address is rx + imm, result lands in ry
                ctrl.use_imm = 1'b1;
                ctrl.reg_we  = 1'b1;
                ctrl.wb_addr = ry;
                ctrl.mem_re  = 1'b1;
            end
            op_sw: begin
                ctrl.use_imm = 1'b1;
                ctrl.mem_we  = 1'b1;
            end
            op_beqz: ctrl.branch = br_if_zero;
            op_b:    ctrl.branch = br_always;
            default: ctrl = '0;
        endcase
    end

    // ************************************************************
    // immediate extension
    // ************************************************************

    always_comb begin
        case (opcode)
            op_addiu, op_beqz: imm = {{8{inst[7]}}, inst[7:0]};
            op_li:             imm = {8'd0, inst[7:0]};
            op_lw, op_sw:      imm = {{11{inst[4]}}, inst[4:0]};
            op_b:              imm = {{5{inst[10]}}, inst[10:0]};
            default:           imm = '0;
        endcase
    end

endmodule

// ==== hdl/cpu16_execute.sv ====
`timescale 1ns/1ps

module cpu16_execute
    import cpu16_pkg::*;
(
    input  id_ex_t   id_ex,
    input  fwd_sel_e fwd_a,
    input  fwd_sel_e fwd_b,
    input  word_t    mem_fwd,
    input  word_t    wb_fwd,
    output ex_mem_t  ex_mem,
    output logic     branch_taken,
    output pc_t      branch_target
);

    word_t rx_val;
    word_t ry_val;
    word_t op_b;
    word_t result;

    function automatic word_t pick_operand(
        input fwd_sel_e sel,
        input word_t    reg_val,
        input word_t    mem_val,
        input word_t    wb_val
    );
        case (sel)
            fwd_from_mem: return mem_val;
            fwd_from_wb:  return wb_val;
            default:      return reg_val;
        endcase
    endfunction

    assign rx_val = pick_operand(fwd_a, id_ex.rx_data, mem_fwd, wb_fwd);
    assign ry_val = pick_operand(fwd_b, id_ex.ry_data, mem_fwd, wb_fwd);
    assign op_b   = id_ex.ctrl.use_imm ? id_ex.imm : ry_val;

    // alu, operand a is always rx
    always_comb begin
        case (id_ex.ctrl.alu_op)
            alu_add:    result = rx_val + op_b;
            alu_sub:    result = rx_val - op_b;
            alu_and:    result = rx_val & op_b;
            alu_or:     result = rx_val | op_b;
            alu_pass_b: result = op_b;
            default:    result = '0;
        endcase
    end

    // branch resolution
    always_comb begin
        case (id_ex.ctrl.branch)
            br_always:  branch_taken = 1'b1;
            br_if_zero: branch_taken = (rx_val == '0);
            default:    branch_taken = 1'b0;
        endcase
    end

    assign branch_target = id_ex.pc_next + id_ex.imm;

    assign ex_mem.reg_we     = id_ex.ctrl.reg_we;
    assign ex_mem.mem_re     = id_ex.ctrl.mem_re;
    assign ex_mem.mem_we     = id_ex.ctrl.mem_we;
    assign ex_mem.wb_addr    = id_ex.ctrl.wb_addr;
    assign ex_mem.alu_result = result;
    assign ex_mem.store_data = ry_val;

endmodule

// ==== hdl/cpu16_hazard.sv ====
`timescale 1ns/1ps

module cpu16_hazard
    import cpu16_pkg::*;
(
    input  reg_addr_t rx_addr,
    input  reg_addr_t ry_addr,
    input  id_ex_t    id_ex,
    input  ex_mem_t   ex_mem,
    input  mem_wb_t   mem_wb,
    output logic      stall,
    output fwd_sel_e  fwd_a,
    output fwd_sel_e  fwd_b
);

    logic load_in_ex;

    // newest producer wins
    function automatic fwd_sel_e fwd_select(
        input reg_addr_t src,
        input ex_mem_t   em,
        input mem_wb_t   mw
    );
        if (em.reg_we && em.wb_addr == src) begin
            return fwd_from_mem;
        end else if (mw.reg_we && mw.wb_addr == src) begin
            return fwd_from_wb;
        end
        return fwd_from_reg;
    endfunction

    // ************************************************************
    // load-use stall
    // ************************************************************

    // load data is only ready after the memory stage, one bubble needed
    assign load_in_ex = id_ex.ctrl.mem_re && id_ex.ctrl.reg_we;
    assign stall = load_in_ex &&
                   (id_ex.ctrl.wb_addr == rx_addr || id_ex.ctrl.wb_addr == ry_addr);

    // ************************************************************
    // forwarding selects
    // ************************************************************

    assign fwd_a = fwd_select(id_ex.rx_addr, ex_mem, mem_wb);
    assign fwd_b = fwd_select(id_ex.ry_addr, ex_mem, mem_wb);

endmodule

// ==== hdl/cpu16_pkg.sv ====
package cpu16_pkg;

    // ************************************************************
    // widths
    // ************************************************************

    typedef logic [15:0] word_t;
    typedef logic [15:0] pc_t;
    typedef logic [15:0] inst_t;
    typedef logic [2:0]  reg_addr_t;

    localparam int num_regs = 8;

    // ************************************************************
    // instruction encoding
    // ************************************************************

    // major opcode in bits 15:11
    typedef enum logic [4:0] {
        op_nop   = 5'b00001,
        op_b     = 5'b00010,
        op_beqz  = 5'b00100,
        op_addiu = 5'b01001,
        op_li    = 5'b01101,
        op_lw    = 5'b10011,
        op_sw    = 5'b11011,
        op_rtype = 5'b11100
    } opcode_e;

    // r-type function field, bits 1:0
    localparam logic [1:0] funct_and  = 2'b00;
    localparam logic [1:0] funct_addu = 2'b01;
    localparam logic [1:0] funct_or   = 2'b10;
    localparam logic [1:0] funct_subu = 2'b11;

    // bubble instruction for IF/ID
    localparam inst_t inst_nop = {op_nop, 11'd0};

    // ************************************************************
    // control and pipeline registers
    // ************************************************************

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_pass_b
    } alu_op_e;

    typedef enum logic [1:0] {
        br_none,
        br_always,
        br_if_zero
    } branch_e;

    typedef enum logic [1:0] {
        fwd_from_reg,
        fwd_from_mem,
        fwd_from_wb
    } fwd_sel_e;

    // all-zero value is a bubble
    typedef struct packed {
        alu_op_e   alu_op;
        logic      use_imm;
        logic      reg_we;
        reg_addr_t wb_addr;
        logic      mem_re;
        logic      mem_we;
        branch_e   branch;
    } ctrl_t;

    typedef struct packed {
        ctrl_t     ctrl;
        pc_t       pc_next;
        reg_addr_t rx_addr;
        reg_addr_t ry_addr;
        word_t     rx_data;
        word_t     ry_data;
        word_t     imm;
    } id_ex_t;

    typedef struct packed {
        logic      reg_we;
        logic      mem_re;
        logic      mem_we;
        reg_addr_t wb_addr;
        word_t     alu_result;
        word_t     store_data;
    } ex_mem_t;

    typedef struct packed {
        logic      reg_we;
        reg_addr_t wb_addr;
        word_t     wb_data;
    } mem_wb_t;

endpackage

// ==== hdl/cpu16_regfile.sv ====
`timescale 1ns/1ps

module cpu16_regfile
    import cpu16_pkg::*;
(
    input  logic      clk_50MHz,
    input  logic      rst,
    input  reg_addr_t rx_addr,
    input  reg_addr_t ry_addr,
    input  mem_wb_t   wb,
    output word_t     rx_data,
    output word_t     ry_data
);

    word_t regs [num_regs];

    always_ff @(posedge clk_50MHz or negedge rst) begin
        if (!rst) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.reg_we) begin
            regs[wb.wb_addr] <= wb.wb_data;
        end
    end

    // write-through so decode sees the value retiring this cycle
    assign rx_data = (wb.reg_we && wb.wb_addr == rx_addr) ? wb.wb_data : regs[rx_addr];
    assign ry_data = (wb.reg_we && wb.wb_addr == ry_addr) ? wb.wb_data : regs[ry_addr];

endmodule

// ==== hdl/cpu16_top.sv ====
`timescale 1ns/1ps

module cpu16_top
    import cpu16_pkg::*;
#(
    parameter pc_t reset_pc = '0
) (
    input  logic  clk_50MHz,
    input  logic  rst,
    output pc_t   imem_addr,
    input  inst_t imem_data,
    output word_t dmem_addr,
    output word_t dmem_wdata,
    output logic  dmem_we,
    output logic  dmem_re,
    input  word_t dmem_rdata
);

    pc_t      pc_q;
    pc_t      pc_plus1;
    inst_t    if_inst_q;
    pc_t      if_pc_next_q;
    ctrl_t    id_ctrl;
    word_t    id_imm;
    reg_addr_t id_rx_addr;
    reg_addr_t id_ry_addr;
    word_t    id_rx_data;
    word_t    id_ry_data;
    id_ex_t   id_ex_d;
    id_ex_t   id_ex_q;
    ex_mem_t  ex_mem_d;
    ex_mem_t  ex_mem_q;
    mem_wb_t  mem_wb_d;
    mem_wb_t  mem_wb_q;
    logic     stall;
    fwd_sel_e fwd_a;
    fwd_sel_e fwd_b;
    logic     branch_taken;
    pc_t      branch_target;

    // ************************************************************
    // fetch
    // ************************************************************

    assign pc_plus1  = pc_q + 16'd1;
    assign imem_addr = pc_q;

    always_ff @(posedge clk_50MHz or negedge rst) begin
        if (!rst) begin
            pc_q <= reset_pc;
        end else if (branch_taken) begin
            pc_q <= branch_target;
        end else if (!stall) begin
            pc_q <= pc_plus1;
        end
    end

    // IF/ID, holds on stall, flushed by a taken branch
    always_ff @(posedge clk_50MHz or negedge rst) begin
        if (!rst) begin
            if_inst_q    <= inst_nop;
            if_pc_next_q <= reset_pc;
        end else if (branch_taken) begin
            if_inst_q <= inst_nop;
        end else if (!stall) begin
            if_inst_q    <= imem_data;
            if_pc_next_q <= pc_plus1;
        end
    end

    // ************************************************************
    // decode
    // ************************************************************

    assign id_rx_addr = if_inst_q[10:8];
    assign id_ry_addr = if_inst_q[7:5];

    cpu16_decode u_decode (
        .inst (if_inst_q),
        .ctrl (id_ctrl),
        .imm  (id_imm)
    );

    cpu16_regfile u_regfile (
        .clk_50MHz (clk_50MHz),
        .rst       (rst),
        .rx_addr   (id_rx_addr),
        .ry_addr   (id_ry_addr),
        .wb        (mem_wb_q),
        .rx_data   (id_rx_data),
        .ry_data   (id_ry_data)
    );

    cpu16_hazard u_hazard (
        .rx_addr (id_rx_addr),
        .ry_addr (id_ry_addr),
        .id_ex   (id_ex_q),
        .ex_mem  (ex_mem_q),
        .mem_wb  (mem_wb_q),
        .stall   (stall),
        .fwd_a   (fwd_a),
        .fwd_b   (fwd_b)
    );

    assign id_ex_d = '{
        ctrl:    id_ctrl,
        pc_next: if_pc_next_q,
        rx_addr: id_rx_addr,
        ry_addr: id_ry_addr,
        rx_data: id_rx_data,
        ry_data: id_ry_data,
        imm:     id_imm
    };

    // bubble on load-use stall or taken branch
    always_ff @(posedge clk_50MHz or negedge rst) begin
        if (!rst) begin
            id_ex_q <= '0;
        end else if (branch_taken || stall) begin
            id_ex_q <= '0;
        end else begin
            id_ex_q <= id_ex_d;
        end
    end

    // ************************************************************
    // execute, memory, writeback
    // ************************************************************

    cpu16_execute u_execute (
        .id_ex         (id_ex_q),
        .fwd_a         (fwd_a),
        .fwd_b         (fwd_b),
        .mem_fwd       (ex_mem_q.alu_result),
        .wb_fwd        (mem_wb_q.wb_data),
        .ex_mem        (ex_mem_d),
        .branch_taken  (branch_taken),
        .branch_target (branch_target)
    );

    always_ff @(posedge clk_50MHz or negedge rst) begin
        if (!rst) begin
            ex_mem_q <= '0;
            mem_wb_q <= '0;
        end else begin
            ex_mem_q <= ex_mem_d;
            mem_wb_q <= mem_wb_d;
        end
    end

    assign dmem_addr  = ex_mem_q.alu_result;
    assign dmem_wdata = ex_mem_q.store_data;
    assign dmem_we    = ex_mem_q.mem_we;
    assign dmem_re    = ex_mem_q.mem_re;

    // load data arrives in the same cycle
    assign mem_wb_d.reg_we  = ex_mem_q.reg_we;
    assign mem_wb_d.wb_addr = ex_mem_q.wb_addr;
    assign mem_wb_d.wb_data = ex_mem_q.mem_re ? dmem_rdata : ex_mem_q.alu_result;

endmodule
